/* filelist.f */
src/swr_pkg.sv
src/rr_arbiter.sv
src/input_port.sv
src/shared_flit_buffer.sv
src/output_port.sv
src/shared_buffer_router.sv
testbench/router_props.sv
testbench/tb_router.sv

/* Makefile */
# Verilator flow for the shared-buffer router testbench
VERILATOR ?= verilator
TOP       ?= tb_router
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_router.sv */
// assumes the default depths below match the DUT; fixed LFSR seed so every run repeats
`timescale 1ns/100ps

module tb_router;

   localparam int          NP           = swr_pkg::NUM_PORTS;
   localparam int          STAGE_DEPTH  = 4;
   localparam int          QUEUE_DEPTH  = 8;
   localparam int          DOWN_CREDITS = 4;
   localparam logic [31:0] SEED         = 32'h4d66_b67e;
   // cycle limits for the waits
   localparam int          SEND_LIMIT   = 4000;
   localparam int          DRAIN_LIMIT  = 2000;

   logic               clk   = 1'b0;
   logic               rst_n = 1'b0;
   swr_pkg::flit_t     channel_in  [NP];
   swr_pkg::port_vec_t credit_out;
   swr_pkg::flit_t     channel_out [NP];
   swr_pkg::port_vec_t credit_in;
   logic               error;

   // sender, receiver and scoreboard state
   logic [31:0]        lfsr_state = SEED;
   int                 up_credits [NP];
   int                 sent       [NP];
   int                 pulses     [NP];
   int                 delivered  [NP];
   int                 returned   [NP];
   int                 tx_seq     [NP][NP];
   int                 rx_seq     [NP][NP];
   // outputs whose downstream credits are withheld
   swr_pkg::port_vec_t hold = '0;

   always #5 clk = ~clk;

   shared_buffer_router #(
      .STAGE_DEPTH(STAGE_DEPTH), .QUEUE_DEPTH(QUEUE_DEPTH), .DOWN_CREDITS(DOWN_CREDITS)
   ) u_dut (
      .clk(clk), .rst_n(rst_n), .channel_in(channel_in), .credit_out(credit_out),
      .channel_out(channel_out), .credit_in(credit_in), .error(error));

   // ------------------------------------------------------------------------
   // random source and reference model
   // ------------------------------------------------------------------------
   // Galois LFSR, one step per bit taken
   function automatic logic next_rand_bit();
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      return lfsr_state[0];
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++)
         v = (v << 1) | int'(next_rand_bit());
      return v;
   endfunction

   // tag, source, destination, then sequence number in the low half
   function automatic logic [31:0] expected_data(input int src, input int dst, input int seq);
      return {8'hc3, 2'(src), 2'(dst), 4'h0, 16'(seq)};
   endfunction

   function automatic int total_sent();
      int t;
      t = 0;
      for (int s = 0; s < NP; s++)
         t += sent[s];
      return t;
   endfunction

   // every flit out and every downstream credit home
   function automatic logic drained();
      logic ok;
      ok = 1'b1;
      for (int a = 0; a < NP; a++)
      begin
         if (returned[a] != delivered[a])
            ok = 1'b0;
         for (int b = 0; b < NP; b++)
            if (rx_seq[a][b] != tx_seq[a][b])
               ok = 1'b0;
      end
      return ok;
   endfunction

   // ------------------------------------------------------------------------
   // reporting
   // ------------------------------------------------------------------------
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
         fail_run($sformatf("CHECK FAILED at time %0t: %s = 0x%0h, expected 0x%0h",
                            $time, name, actual, expected));
   endtask

   // ------------------------------------------------------------------------
   // stimulus, one call per falling edge
   // ------------------------------------------------------------------------
   // dest_sel below zero picks a random destination
   task automatic drive_cycle(input logic send_en, input int dest_sel,
                              input swr_pkg::port_vec_t src_mask);
      int dst;
      @(negedge clk);
      for (int s = 0; s < NP; s++)
      begin
         if (credit_out[s])
         begin
            up_credits[s]++;
            pulses[s]++;
         end
         if (up_credits[s] > STAGE_DEPTH)
            fail_run($sformatf("upstream credits of input %0d rose above STAGE_DEPTH", s));
         channel_in[s] = '0;
         if (send_en && src_mask[s] && (up_credits[s] > 0) && next_rand_bit())
         begin
            dst = (dest_sel < 0) ? rand_bits(2) : dest_sel;
            channel_in[s] = swr_pkg::flit_t'{valid: 1'b1, dest: swr_pkg::port_idx_t'(dst),
                                             data: expected_data(s, dst, tx_seq[s][dst])};
            tx_seq[s][dst]++;
            sent[s]++;
            up_credits[s]--;
         end
      end
      // downstream receivers give credits back after a random delay
      for (int o = 0; o < NP; o++)
      begin
         credit_in[o] = 1'b0;
         if (!hold[o] && (returned[o] < delivered[o]) && next_rand_bit())
         begin
            credit_in[o] = 1'b1;
            returned[o]++;
         end
      end
   endtask

   task automatic send_flits(input int count, input int dest_sel,
                             input swr_pkg::port_vec_t src_mask);
      int target;
      int cycles;
      target = total_sent() + count;
      cycles = 0;
      while (total_sent() < target)
      begin
         if (cycles == SEND_LIMIT)
            fail_run("timeout: the sources could not place all their flits");
         drive_cycle(1'b1, dest_sel, src_mask);
         cycles++;
      end
   endtask

   task automatic drain_and_check();
      int cycles;
      cycles = 0;
      while (!drained())
      begin
         if (cycles == DRAIN_LIMIT)
            fail_run("timeout: flits or credits still outstanding after traffic stopped");
         drive_cycle(1'b0, -1, '0);
         cycles++;
      end
      for (int s = 0; s < NP; s++)
         check_value($sformatf("credit_out[%0d] pulses", s), 32'(pulses[s]), 32'(sent[s]));
      check_value("error", 32'(error), 32'(0));
   endtask

   // 8 cycles of reset, model cleared, then the idle state is checked
   task automatic apply_reset();
      rst_n     = 1'b0;
      hold      = '0;
      credit_in = '0;
      for (int a = 0; a < NP; a++)
      begin
         channel_in[a] = '0;
         up_credits[a] = STAGE_DEPTH;
         sent[a]       = 0;
         pulses[a]     = 0;
         delivered[a]  = 0;
         returned[a]   = 0;
         for (int b = 0; b < NP; b++)
         begin
            tx_seq[a][b] = 0;
            rx_seq[a][b] = 0;
         end
      end
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      check_value("credit_out", 32'(credit_out), 32'(0));
      for (int o = 0; o < NP; o++)
         check_value($sformatf("channel_out[%0d].valid", o), 32'(channel_out[o].valid), 32'(0));
      check_value("error", 32'(error), 32'(0));
   endtask

   // ------------------------------------------------------------------------
   // compare process
   // ------------------------------------------------------------------------
   // outputs held over the whole cycle, read before the edge updates them
   always @(posedge clk)
   begin : compare_outputs
      int src;
      if (rst_n)
      begin
         for (int o = 0; o < NP; o++)
         begin
            if (channel_out[o].valid)
            begin
               src = int'(channel_out[o].data[23:22]);
               check_value($sformatf("channel_out[%0d].dest", o),
                           32'(channel_out[o].dest), 32'(o));
               check_value($sformatf("channel_out[%0d].data", o), channel_out[o].data,
                           expected_data(src, o, rx_seq[src][o]));
               rx_seq[src][o]++;
               delivered[o]++;
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial
   begin : main
      int base;
      int cycles;
      for (int a = 0; a < NP; a++)
         channel_in[a] = '0;
      credit_in = '0;
      apply_reset();

      // mixed traffic to every output
      send_flits(240, -1, '1);
      drain_and_check();

      // output 0 starved of credits while all four inputs aim at it
      hold[0] = 1'b1;
      base    = delivered[0];
      send_flits(16, 0, '1);
      cycles = 0;
      while ((delivered[0] - base) < DOWN_CREDITS)
      begin
         if (cycles == DRAIN_LIMIT)
            fail_run("timeout: output 0 never used its downstream credits");
         drive_cycle(1'b0, -1, '0);
         cycles++;
      end
      repeat (40) drive_cycle(1'b0, -1, '0);
      check_value("channel_out[0] flits while starved", 32'(delivered[0] - base),
                  32'(DOWN_CREDITS));
      hold[0] = 1'b0;
      drain_and_check();

      // all inputs to one output with credits flowing
      send_flits(80, 2, '1);
      drain_and_check();

      // fill output 1 path from input 0 until no credit is left
      hold[1] = 1'b1;
      send_flits(DOWN_CREDITS + QUEUE_DEPTH + STAGE_DEPTH, 1, 4'b0001);
      check_value("upstream credits of input 0", 32'(up_credits[0]), 32'(0));
      // one flit with no credit behind it
      @(negedge clk);
      channel_in[0] = swr_pkg::flit_t'{valid: 1'b1, dest: 2'd1, data: 32'h0bad_f117};
      cycles = 0;
      while (!error)
      begin
         if (cycles == 20)
            fail_run("timeout: error did not rise after a flit sent without credit");
         drive_cycle(1'b0, -1, '0);
         cycles++;
      end
      // sticky until reset
      repeat (20)
      begin
         drive_cycle(1'b0, -1, '0);
         check_value("error", 32'(error), 32'(1));
      end
      apply_reset();

      $display("Test OK");
      $finish;
   end

endmodule

/* testbench/router_props.sv */
// checks are off during reset; output timing assumes the two-cycle grant to channel_out pipe
`timescale 1ns/100ps

module router_props (
   input logic               clk,
   input logic               rst_n,
   input swr_pkg::port_vec_t wr_gnt,
   input swr_pkg::port_vec_t rd_gnt,
   input swr_pkg::port_vec_t queue_nonempty,
   input swr_pkg::port_vec_t has_credit,
   input swr_pkg::flit_t     channel_out [swr_pkg::NUM_PORTS]
);

   // at most one winner per arbiter
   a_wr_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_gnt))
      else $error("write grant is not one-hot");
   a_rd_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_gnt))
      else $error("read grant is not one-hot");

   // never pop a queue with nothing in it
   a_rd_gnt_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_gnt & ~queue_nonempty) == '0)
      else $error("read grant given to an empty queue");

   // each valid output flit was paid for by a credited grant two cycles before
   for (genvar o = 0; o < swr_pkg::NUM_PORTS; o++)
   begin : g_out
      a_out_credited: assert property (@(posedge clk) disable iff (!rst_n)
         channel_out[o].valid |-> $past(has_credit[o], 2))
         else $error("channel_out valid although its credit count was zero");
   end

endmodule

bind shared_buffer_router router_props u_props (
   .clk(clk), .rst_n(rst_n), .wr_gnt(wr_gnt), .rd_gnt(rd_gnt),
   .queue_nonempty(queue_nonempty), .channel_out(channel_out),
   .has_credit({g_out[3].u_out.credits != '0, g_out[2].u_out.credits != '0,
                g_out[1].u_out.credits != '0, g_out[0].u_out.credits != '0}));

/* src/shared_buffer_router.sv */
// each flit names its own output; error is sticky and only rst_n clears it
`timescale 1ns/100ps

module shared_buffer_router #(
   parameter int STAGE_DEPTH  = 4,
   parameter int QUEUE_DEPTH  = 8,
   parameter int DOWN_CREDITS = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  swr_pkg::flit_t     channel_in  [swr_pkg::NUM_PORTS],
   output swr_pkg::port_vec_t credit_out,
   output swr_pkg::flit_t     channel_out [swr_pkg::NUM_PORTS],
   input  swr_pkg::port_vec_t credit_in,
   output logic               error
);

   localparam int NP = swr_pkg::NUM_PORTS;

   swr_pkg::port_vec_t wr_req;
   swr_pkg::port_vec_t wr_gnt;
   swr_pkg::port_vec_t rd_req;
   swr_pkg::port_vec_t rd_gnt;
   swr_pkg::port_vec_t queue_full;
   swr_pkg::port_vec_t queue_nonempty;
   swr_pkg::port_vec_t overflow;
   swr_pkg::port_vec_t credit_error;
   swr_pkg::flit_t     head_flit [NP];
   swr_pkg::flit_t     wr_flit;
   swr_pkg::flit_t     rd_flit;
   logic               error_q;

   // ------------------------------------------------------------------------
   // input side and write arbitration
   // ------------------------------------------------------------------------
   for (genvar ip = 0; ip < NP; ip++)
   begin : g_in
      input_port #(.STAGE_DEPTH(STAGE_DEPTH)) u_in (
         .clk(clk), .rst_n(rst_n), .channel_in(channel_in[ip]),
         .queue_full(queue_full), .wr_gnt(wr_gnt[ip]), .wr_req(wr_req[ip]),
         .head_flit(head_flit[ip]), .credit_out(credit_out[ip]), .overflow(overflow[ip]));
   end

   rr_arbiter #(.WIDTH(NP)) u_wr_arb (.clk(clk), .rst_n(rst_n), .req(wr_req), .gnt(wr_gnt));

   // winning head flit goes to the buffer
   always_comb
   begin
      wr_flit = '0;
      for (int p = 0; p < NP; p++)
         if (wr_gnt[p])
            wr_flit = head_flit[p];
      wr_flit.valid = |wr_gnt;
   end

   shared_flit_buffer #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_buf (
      .clk(clk), .rst_n(rst_n), .wr_en(|wr_gnt), .wr_flit(wr_flit), .rd_gnt(rd_gnt),
      .rd_flit(rd_flit), .queue_full(queue_full), .queue_nonempty(queue_nonempty));

   // ------------------------------------------------------------------------
   // read arbitration and output side
   // ------------------------------------------------------------------------
   rr_arbiter #(.WIDTH(NP)) u_rd_arb (.clk(clk), .rst_n(rst_n), .req(rd_req), .gnt(rd_gnt));

   for (genvar op = 0; op < NP; op++)
   begin : g_out
      output_port #(.DOWN_CREDITS(DOWN_CREDITS)) u_out (
         .clk(clk), .rst_n(rst_n), .queue_nonempty(queue_nonempty[op]),
         .rd_gnt(rd_gnt[op]), .rd_flit(rd_flit), .credit_in(credit_in[op]),
         .rd_req(rd_req[op]), .channel_out(channel_out[op]),
         .credit_error(credit_error[op]));
   end

   // sticky error over all ports
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         error_q <= 1'b0;
      else
         error_q <= error_q | (|overflow) | (|credit_error);
   end

   assign error = error_q;

endmodule

/* src/output_port.sv */
// downstream must return at most DOWN_CREDITS credits; extra credits are dropped and flagged
`timescale 1ns/100ps

module output_port #(
   parameter int DOWN_CREDITS = 4
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           queue_nonempty,
   input  logic           rd_gnt,
   input  swr_pkg::flit_t rd_flit,
   input  logic           credit_in,
   output logic           rd_req,
   output swr_pkg::flit_t channel_out,
   output logic           credit_error
);

   localparam int CW = $clog2(DOWN_CREDITS + 1);

   // credits held toward the downstream receiver
   logic [CW-1:0] credits;
   // our grant last cycle, so rd_flit belongs to us now
   logic          gnt_q;

   // channel register, payload without reset
   logic                                out_valid;
   swr_pkg::port_idx_t                  out_dest;
   logic [swr_pkg::FLIT_DATA_WIDTH-1:0] out_data;

   // ask only with data waiting and a credit in hand
   assign rd_req = queue_nonempty & (credits != '0);

   // a returned credit on a full counter with nothing spent is a protocol error
   assign credit_error = credit_in & ~rd_gnt & (credits == CW'(DOWN_CREDITS));

   // ------------------------------------------------------------------------
   // credit counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         credits <= CW'(DOWN_CREDITS);
         gnt_q   <= 1'b0;
      end
      else
      begin
         gnt_q <= rd_gnt;
         // spend in the grant cycle, refill on credit_in
         if (rd_gnt && !credit_in)
            credits <= credits - 1'b1;
         else if (!rd_gnt && credit_in && !credit_error)
            credits <= credits + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // output channel
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else
         out_valid <= gnt_q & rd_flit.valid;
   end

   always_ff @(posedge clk)
   begin
      if (gnt_q)
      begin
         out_dest <= rd_flit.dest;
         out_data <= rd_flit.data;
      end
   end

   assign channel_out = swr_pkg::flit_t'{valid: out_valid, dest: out_dest, data: out_data};

endmodule

/* src/shared_flit_buffer.sv */
// one write and one read per cycle; writer must check queue_full since no room check is done here
`timescale 1ns/100ps

module shared_flit_buffer #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               wr_en,
   input  swr_pkg::flit_t     wr_flit,
   input  swr_pkg::port_vec_t rd_gnt,
   output swr_pkg::flit_t     rd_flit,
   output swr_pkg::port_vec_t queue_full,
   output swr_pkg::port_vec_t queue_nonempty
);

   localparam int NQ     = swr_pkg::NUM_PORTS;
   localparam int DEPTH  = NQ * QUEUE_DEPTH;
   localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

   // flat memory, queue q owns entries q*QUEUE_DEPTH and up
   logic [swr_pkg::FLIT_DATA_WIDTH-1:0] mem [DEPTH];

   logic [QPTR_W-1:0] head_ptr [NQ];
   logic [QPTR_W-1:0] tail_ptr [NQ];
   logic [QCNT_W-1:0] count    [NQ];

   swr_pkg::port_vec_t push_vec;
   swr_pkg::port_idx_t rd_idx;
   logic [ADDR_W-1:0]  wr_addr;
   logic [ADDR_W-1:0]  rd_addr;

   // read register, valid is the only reset bit
   logic                                rd_valid_q;
   swr_pkg::port_idx_t                  rd_dest_q;
   logic [swr_pkg::FLIT_DATA_WIDTH-1:0] rd_data_q;

   // ------------------------------------------------------------------------
   // address decode
   // ------------------------------------------------------------------------
   // valid qualifies the write strobe
   assign push_vec = (wr_en && wr_flit.valid) ? (swr_pkg::port_vec_t'(1) << wr_flit.dest) : '0;

   // one-hot read grant to queue index
   always_comb
   begin
      rd_idx = '0;
      for (int q = 0; q < NQ; q++)
         if (rd_gnt[q])
            rd_idx = swr_pkg::port_idx_t'(q);
   end

   assign wr_addr = ADDR_W'(int'(wr_flit.dest) * QUEUE_DEPTH + int'(tail_ptr[wr_flit.dest]));
   assign rd_addr = ADDR_W'(int'(rd_idx) * QUEUE_DEPTH + int'(head_ptr[rd_idx]));

   // ------------------------------------------------------------------------
   // storage and queue state
   // ------------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (|push_vec)
         mem[wr_addr] <= wr_flit.data;
      if (|rd_gnt)
      begin
         rd_dest_q <= rd_idx;
         rd_data_q <= mem[rd_addr];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_valid_q <= 1'b0;
         for (int q = 0; q < NQ; q++)
         begin
            head_ptr[q] <= '0;
            tail_ptr[q] <= '0;
            count[q]    <= '0;
         end
      end
      else
      begin
         rd_valid_q <= |rd_gnt;
         for (int q = 0; q < NQ; q++)
         begin
            if (push_vec[q])
               tail_ptr[q] <= (tail_ptr[q] == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : tail_ptr[q] + 1'b1;
            if (rd_gnt[q])
               head_ptr[q] <= (head_ptr[q] == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : head_ptr[q] + 1'b1;
            // push and pop together leave the count alone
            if (push_vec[q] && !rd_gnt[q])
               count[q] <= count[q] + 1'b1;
            else if (!push_vec[q] && rd_gnt[q])
               count[q] <= count[q] - 1'b1;
         end
      end
   end

   // status straight from the counts
   always_comb
   begin
      for (int q = 0; q < NQ; q++)
      begin
         queue_full[q]     = (count[q] == QCNT_W'(QUEUE_DEPTH));
         queue_nonempty[q] = (count[q] != '0);
      end
   end

   assign rd_flit = swr_pkg::flit_t'{valid: rd_valid_q, dest: rd_dest_q, data: rd_data_q};

endmodule

/* src/input_port.sv */
// sender must respect credits; a flit that arrives on a full FIFO is dropped and flagged
`timescale 1ns/100ps

module input_port #(
   parameter int STAGE_DEPTH = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  swr_pkg::flit_t     channel_in,
   input  swr_pkg::port_vec_t queue_full,
   input  logic               wr_gnt,
   output logic               wr_req,
   output swr_pkg::flit_t     head_flit,
   output logic               credit_out,
   output logic               overflow
);

   localparam int PTR_W = (STAGE_DEPTH > 1) ? $clog2(STAGE_DEPTH) : 1;
   localparam int CNT_W = $clog2(STAGE_DEPTH + 1);

   // ------------------------------------------------------------------------
   // staging FIFO
   // ------------------------------------------------------------------------
   swr_pkg::port_idx_t                  dest_mem [STAGE_DEPTH];
   logic [swr_pkg::FLIT_DATA_WIDTH-1:0] data_mem [STAGE_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic             fifo_full;
   logic             fifo_empty;
   logic             push;
   logic             pop;

   assign fifo_full  = (fill == CNT_W'(STAGE_DEPTH));
   assign fifo_empty = (fill == '0);

   // arrivals on a full FIFO are lost
   assign push     = channel_in.valid & ~fifo_full;
   assign overflow = channel_in.valid & fifo_full;
   assign pop      = wr_gnt & ~fifo_empty;

   // payload storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         dest_mem[wr_ptr] <= channel_in.dest;
         data_mem[wr_ptr] <= channel_in.data;
      end
   end

   // pointers, fill level and credit return
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill       <= '0;
         credit_out <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(STAGE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(STAGE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            fill <= fill + 1'b1;
         else if (!push && pop)
            fill <= fill - 1'b1;
         // one credit back per slot freed
         credit_out <= pop;
      end
   end

   // ------------------------------------------------------------------------
   // request toward the shared buffer
   // ------------------------------------------------------------------------
   assign head_flit = swr_pkg::flit_t'{valid: ~fifo_empty,
                                       dest:  dest_mem[rd_ptr],
                                       data:  data_mem[rd_ptr]};

   // hold off while the target queue has no room
   assign wr_req = ~fifo_empty & ~queue_full[head_flit.dest];

endmodule

/* src/rr_arbiter.sv */
// grant is combinational from req; priority only advances on a grant, so a lone requester wins
`timescale 1ns/100ps

module rr_arbiter #(
   parameter int WIDTH = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] req,
   output logic [WIDTH-1:0] gnt
);

   localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

   // first requester index searched this cycle
   logic [PTR_W-1:0] prio_ptr;
   // index of this cycle's winner
   logic [PTR_W-1:0] win_idx;

   // scan from prio_ptr upward with wrap, first hit wins
   always_comb
   begin : search
      int idx;
      gnt     = '0;
      win_idx = prio_ptr;
      for (int i = 0; i < WIDTH; i++)
      begin
         idx = (int'(prio_ptr) + i) % WIDTH;
         if (req[idx] && (gnt == '0))
         begin
            gnt[idx] = 1'b1;
            win_idx  = PTR_W'(idx);
         end
      end
   end

   // move priority to the port after the winner
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         prio_ptr <= '0;
      else if (|gnt)
         prio_ptr <= (win_idx == PTR_W'(WIDTH - 1)) ? '0 : win_idx + 1'b1;
   end

endmodule

/* src/swr_pkg.sv */
// port count is fixed at 4 since the flit and vector widths derive from it; change all together
package swr_pkg;

   // ------------------------------------------------------------------------
   // switch geometry
   // ------------------------------------------------------------------------

   // number of input ports and of output ports
   localparam int NUM_PORTS = 4;

   // bits needed to name one port
   localparam int PORT_IDX_WIDTH = 2;

   // payload width carried by each flit
   localparam int FLIT_DATA_WIDTH = 32;

   // ------------------------------------------------------------------------
   // shared types
   // ------------------------------------------------------------------------

   // port number, used as the flit destination and the queue index
   typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

   // one bit per port
   // requests, grants, queue status, credits and errors all use this
   typedef logic [NUM_PORTS-1:0] port_vec_t;

   // flit as seen on every channel and internal flit path
   // valid marks a live flit, dest names the output port
   typedef struct packed {
      logic                       valid;
      port_idx_t                  dest;
      logic [FLIT_DATA_WIDTH-1:0] data;
   } flit_t;

endpackage
